// ==== div_pkg.sv ====
//----------------------------------------------------------------------
// shared definitions for the iterative integer divide unit
// function encoding, width constants and channel payload structs
//----------------------------------------------------------------------

package div_pkg;

  //--------------------------------------------------------------------
  // widths
  //--------------------------------------------------------------------

  // operand and result half width
  localparam int DIV_WIDTH = 32;

  // restoring loop runs one iteration per quotient bit
  localparam int DIV_ITERS = DIV_WIDTH;

  // iteration counter width, counts 0 .. DIV_ITERS-1
  localparam int DIV_CNT_W = $clog2(DIV_ITERS);

  //--------------------------------------------------------------------
  // request function
  //--------------------------------------------------------------------

  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  //--------------------------------------------------------------------
  // channel payloads
  //--------------------------------------------------------------------

  // operand stage -> core, magnitudes plus sign fixups for later
  typedef struct packed {
    logic [DIV_WIDTH-1:0] dividend;
    logic [DIV_WIDTH-1:0] divisor;
    logic                 quot_neg;
    logic                 rem_neg;
  } div_operand_t;

  // core -> result stage, still unsigned magnitudes
  typedef struct packed {
    logic [DIV_WIDTH-1:0] quot;
    logic [DIV_WIDTH-1:0] rem;
    logic                 quot_neg;
    logic                 rem_neg;
  } div_result_t;

endpackage

// ==== div_chan_if.sv ====
//----------------------------------------------------------------------
// valid/ready channel between stages of the divide unit
//----------------------------------------------------------------------

interface div_chan_if #(
  parameter type payload_t = logic
) ();

  // data word, only meaningful while val is high
  payload_t payload;

  // producer has an item
  logic val;

  // consumer can take it this cycle
  logic rdy;

  // transfer happens on a rising edge with val and rdy both high
  // producer keeps payload and val steady until then

  modport producer (
    output payload,
    output val,
    input  rdy
  );

  modport consumer (
    input  payload,
    input  val,
    output rdy
  );

endinterface

// ==== div_operand_stage.sv ====
//----------------------------------------------------------------------
// operand stage: takes requests, strips signs, holds one entry
//----------------------------------------------------------------------

module div_operand_stage (
  input  logic                         clk,
  input  logic                         reset,
  input  div_pkg::div_fn_e             req_fn,
  input  logic [div_pkg::DIV_WIDTH-1:0] req_a,
  input  logic [div_pkg::DIV_WIDTH-1:0] req_b,
  input  logic                         req_val,
  output logic                         req_rdy,
  div_chan_if.producer                 op
);

  import div_pkg::*;

  logic         full_q;
  div_operand_t entry_q;
  div_operand_t entry_d;

  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic accept;

  //--------------------------------------------------------------------
  // sign handling
  //--------------------------------------------------------------------

  // sign bits only count for signed requests
  assign is_signed = (req_fn == DIV_FN_SIGNED);
  assign a_neg     = is_signed & req_a[DIV_WIDTH-1];
  assign b_neg     = is_signed & req_b[DIV_WIDTH-1];

  // two's complement magnitude of negative operands
  // most negative value maps onto itself, which the core reads as 2^31
  assign entry_d.dividend = a_neg ? (~req_a + 1'b1) : req_a;
  assign entry_d.divisor  = b_neg ? (~req_b + 1'b1) : req_b;

  // quotient negative when exactly one operand negative
  // divide by zero keeps the all ones quotient as is
  assign entry_d.quot_neg = (a_neg ^ b_neg) & (req_b != '0);

  // remainder follows the dividend
  assign entry_d.rem_neg  = a_neg;

  //--------------------------------------------------------------------
  // one-entry register
  //--------------------------------------------------------------------

  // room when empty, or when the core takes the entry this cycle
  assign req_rdy = ~full_q | op.rdy;
  assign accept  = req_val & req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (op.rdy) begin
      // drained without refill
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      entry_q <= entry_d;
    end
  end

  assign op.val     = full_q;
  assign op.payload = entry_q;

endmodule

// ==== div_iter_core.sv ====
//----------------------------------------------------------------------
// iterative divider core: idle/calc/done FSM and
// restoring shift-subtract datapath, one quotient bit per clock
//----------------------------------------------------------------------

module div_iter_core (
  input  logic         clk,
  input  logic         reset,
  div_chan_if.consumer op,
  div_chan_if.producer res
);

  import div_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } core_state_e;

  core_state_e          state_q;
  logic [DIV_CNT_W-1:0] cnt_q;

  // {remainder guard + remainder, quotient}
  logic [2*DIV_WIDTH:0] rq_q;
  // divisor parked in the remainder half
  logic [2*DIV_WIDTH:0] dvs_q;

  logic quot_neg_q;
  logic rem_neg_q;

  logic [2*DIV_WIDTH:0] shifted;
  logic [2*DIV_WIDTH:0] diff;
  logic [2*DIV_WIDTH:0] rq_next;

  logic load;
  logic last_iter;
  logic send;

  //--------------------------------------------------------------------
  // handshake
  //--------------------------------------------------------------------

  // only takes new operands with nothing in flight
  assign op.rdy  = (state_q == ST_IDLE);
  assign load    = op.val & op.rdy;

  assign res.val = (state_q == ST_DONE);
  assign send    = res.val & res.rdy;

  assign last_iter = (cnt_q == DIV_CNT_W'(DIV_ITERS - 1));

  //--------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (load) begin
            state_q <= ST_CALC;
            cnt_q   <= '0;
          end
        end
        ST_CALC: begin
          // 32 edges in calc, then the result is ready
          if (last_iter) begin
            state_q <= ST_DONE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_DONE: begin
          // result stage full -> stay here, op.rdy stays low
          if (send) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  //--------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------

  // shift next dividend bit into the remainder half
  assign shifted = rq_q << 1;
  assign diff    = shifted - dvs_q;

  // diff msb set means the divisor did not fit, restore
  assign rq_next = diff[2*DIV_WIDTH] ? {shifted[2*DIV_WIDTH:1], 1'b0}
                                     : {diff[2*DIV_WIDTH:1], 1'b1};

  always_ff @(posedge clk) begin
    if (load) begin
      rq_q       <= {{(DIV_WIDTH+1){1'b0}}, op.payload.dividend};
      dvs_q      <= {1'b0, op.payload.divisor, {DIV_WIDTH{1'b0}}};
      // sign flags just ride along to the result stage
      quot_neg_q <= op.payload.quot_neg;
      rem_neg_q  <= op.payload.rem_neg;
    end else if (state_q == ST_CALC) begin
      rq_q <= rq_next;
    end
  end

  // remainder always below the divisor, guard bit dropped
  assign res.payload.quot     = rq_q[DIV_WIDTH-1:0];
  assign res.payload.rem      = rq_q[2*DIV_WIDTH-1:DIV_WIDTH];
  assign res.payload.quot_neg = quot_neg_q;
  assign res.payload.rem_neg  = rem_neg_q;

endmodule

// ==== div_result_stage.sv ====
//----------------------------------------------------------------------
// result stage: sign fixup, packing and one-entry output buffer
//----------------------------------------------------------------------

module div_result_stage (
  input  logic                            clk,
  input  logic                            reset,
  div_chan_if.consumer                    res,
  output logic [2*div_pkg::DIV_WIDTH-1:0] resp_result,
  output logic                            resp_val,
  input  logic                            resp_rdy
);

  import div_pkg::*;

  logic                   full_q;
  logic [2*DIV_WIDTH-1:0] result_q;

  logic [DIV_WIDTH-1:0] quot_signed;
  logic [DIV_WIDTH-1:0] rem_signed;
  logic                 take;

  //--------------------------------------------------------------------
  // sign fixup
  //--------------------------------------------------------------------

  // negate magnitudes per the flags from the operand stage
  assign quot_signed = res.payload.quot_neg ? (~res.payload.quot + 1'b1)
                                            : res.payload.quot;
  assign rem_signed  = res.payload.rem_neg  ? (~res.payload.rem + 1'b1)
                                            : res.payload.rem;

  //--------------------------------------------------------------------
  // output buffer
  //--------------------------------------------------------------------

  // free when empty or when the response leaves this cycle
  assign res.rdy = ~full_q | resp_rdy;
  assign take    = res.val & res.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (resp_rdy) begin
      full_q <= 1'b0;
    end
  end

  // remainder in the upper half, quotient below
  always_ff @(posedge clk) begin
    if (take) begin
      result_q <= {rem_signed, quot_signed};
    end
  end

  assign resp_val    = full_q;
  assign resp_result = result_q;

endmodule

// ==== int_div_unit.sv ====
//----------------------------------------------------------------------
// iterative 32-bit integer divide unit, top level
// operand stage -> divider core -> result stage
//----------------------------------------------------------------------

module int_div_unit (
  input  logic                            clk,
  input  logic                            reset,

  // request side
  input  div_pkg::div_fn_e                req_fn,
  input  logic [div_pkg::DIV_WIDTH-1:0]   req_a,
  input  logic [div_pkg::DIV_WIDTH-1:0]   req_b,
  input  logic                            req_val,
  output logic                            req_rdy,

  // response side, {remainder, quotient}
  output logic [2*div_pkg::DIV_WIDTH-1:0] resp_result,
  output logic                            resp_val,
  input  logic                            resp_rdy
);

  import div_pkg::*;

  // operand stage -> core
  div_chan_if #(.payload_t(div_operand_t)) op_chan ();

  // core -> result stage
  div_chan_if #(.payload_t(div_result_t)) res_chan ();

  div_operand_stage operand_stage_i (
    .clk     (clk),
    .reset   (reset),
    .req_fn  (req_fn),
    .req_a   (req_a),
    .req_b   (req_b),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .op      (op_chan.producer)
  );

  // 32 cycles per division, one at a time
  div_iter_core iter_core_i (
    .clk   (clk),
    .reset (reset),
    .op    (op_chan.consumer),
    .res   (res_chan.producer)
  );

  div_result_stage result_stage_i (
    .clk         (clk),
    .reset       (reset),
    .res         (res_chan.consumer),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

endmodule

// ==== tb_clock_gen.sv ====
//----------------------------------------------------------------------
// testbench clock, 20 unit period, and 16 cycle reset
//----------------------------------------------------------------------

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset released a little after the 16th rising edge
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule

// ==== int_div_unit_props.sv ====
//----------------------------------------------------------------------
// handshake assertions on the divide unit response port
//----------------------------------------------------------------------

module int_div_unit_props (
  input logic                            clk,
  input logic                            reset,
  input logic [2*div_pkg::DIV_WIDTH-1:0] resp_result,
  input logic                            resp_val,
  input logic                            resp_rdy
);

  // failures seen so far, read by the testbench at the end
  int fail_cnt = 0;

  // stalled response keeps val high and data unchanged
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else begin
      $error("response dropped or changed while stalled");
      fail_cnt++;
    end

  // output buffer comes out of reset empty
  reset_empty_a: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high in the cycle after reset");
      fail_cnt++;
    end

  resp_val_known_a: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(resp_val))
    else begin
      $error("resp_val is unknown");
      fail_cnt++;
    end

endmodule

// ==== int_div_unit_tb.sv ====
//----------------------------------------------------------------------
// divide unit testbench with stimulus, reference model,
// expected-response queue, per-test report and timeout
//----------------------------------------------------------------------

module int_div_unit_tb;

  import div_pkg::*;

  localparam int MAX_CYCLES = 20000;
  localparam int RDY_HIGH   = 0;
  localparam int RDY_RANDOM = 1;
  localparam int RDY_LOW    = 2;

  logic                   clk;
  logic                   reset;
  div_fn_e                req_fn = DIV_FN_UNSIGNED;
  logic [DIV_WIDTH-1:0]   req_a = '0;
  logic [DIV_WIDTH-1:0]   req_b = '0;
  logic                   req_val = 1'b0;
  logic                   req_rdy;
  logic [2*DIV_WIDTH-1:0] resp_result;
  logic                   resp_val;
  logic                   resp_rdy = 1'b1;

  logic [2*DIV_WIDTH-1:0] exp_q[$];
  logic [2*DIV_WIDTH-1:0] want;
  string                  test_name = "none";
  int rdy_mode = RDY_HIGH;
  int err_count = 0;
  int resp_count = 0;
  int test_count = 0;
  int test_errs;
  int test_resps;
  int cycles = 0;

  tb_clock_gen clock_gen_i (.clk(clk), .reset(reset));

  int_div_unit int_div_unit_i (.*);

  bind int_div_unit int_div_unit_props props_i (.*);

  // reference model returning {remainder, quotient}
  function automatic logic [2*DIV_WIDTH-1:0] expected_result(input div_fn_e fn,
      input logic [DIV_WIDTH-1:0] a, input logic [DIV_WIDTH-1:0] b);
    logic signed [DIV_WIDTH-1:0] sa;
    logic signed [DIV_WIDTH-1:0] sb;
    sa = a;
    sb = b;
    if (b == '0) return {a, {DIV_WIDTH{1'b1}}};
    if (fn == DIV_FN_UNSIGNED) return {a % b, a / b};
    // most negative / -1 wraps onto itself
    if (a == 32'h8000_0000 && b == 32'hffff_ffff) return {32'h0, a};
    // truncating division with the remainder taking the dividend sign
    return {sa % sb, sa / sb};
  endfunction

  // starts 2 units after an edge and returns 2 units after the accept edge
  task automatic send_req(input div_fn_e fn, input logic [DIV_WIDTH-1:0] a,
      input logic [DIV_WIDTH-1:0] b);
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    exp_q.push_back(expected_result(fn, a, b));
    #2;
    req_val = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_errs  = err_count;
    test_resps = resp_count;
  endtask

  // waits for every accepted request to come back and returns on a rising edge
  task automatic end_test;
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    test_count++;
    $display("test %s done: %0d responses, %0d errors", test_name,
             resp_count - test_resps, err_count - test_errs);
  endtask

  //--------------------------------------------------------------------
  // response side
  //--------------------------------------------------------------------

  always @(posedge clk) begin
    #2;
    case (rdy_mode)
      RDY_RANDOM: resp_rdy = ($urandom_range(3) != 0);
      RDY_LOW:    resp_rdy = 1'b0;
      default:    resp_rdy = 1'b1;
    endcase
  end

  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      resp_count++;
      assert (exp_q.size() != 0) else begin
        $display("test %s: response arrived with no request outstanding", test_name);
        err_count++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (resp_result == want) else begin
          $display("FAIL %s expected %h actual %h", test_name, want, resp_result);
          err_count++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout in test %s: responses stopped arriving", test_name);
      $display("TB FAILED");
      $finish;
    end
  end

  //--------------------------------------------------------------------
  // tests
  //--------------------------------------------------------------------

  initial begin
    int total;
    void'($urandom(46411));

    // idle outputs across reset with checks from the second edge on
    start_test("reset_idle");
    @(posedge clk);
    while (reset) begin
      @(posedge clk);
      assert (req_rdy === 1'b1 && resp_val === 1'b0) else begin
        $display("FAIL %s expected req_rdy 1 resp_val 0 actual req_rdy %b resp_val %b",
                 test_name, req_rdy, resp_val);
        err_count++;
      end
    end
    end_test();
    #2;

    start_test("unsigned");
    send_req(DIV_FN_UNSIGNED, 100, 7);
    send_req(DIV_FN_UNSIGNED, 32'hffff_ffff, 1);
    send_req(DIV_FN_UNSIGNED, 32'hffff_ffff, 32'hffff_ffff);
    send_req(DIV_FN_UNSIGNED, 5, 10);
    send_req(DIV_FN_UNSIGNED, 0, 3);
    send_req(DIV_FN_UNSIGNED, 32'h8000_0000, 3);
    // half of the divisors small so quotients get wide
    repeat (50) begin
      send_req(DIV_FN_UNSIGNED, $urandom,
               ($urandom_range(1) != 0) ? $urandom : $urandom_range(1000, 1));
    end
    end_test();
    #2;

    start_test("signed");
    send_req(DIV_FN_SIGNED, 7, 2);
    send_req(DIV_FN_SIGNED, -7, 2);
    send_req(DIV_FN_SIGNED, 7, -2);
    send_req(DIV_FN_SIGNED, -7, -2);
    send_req(DIV_FN_SIGNED, -100, 7);
    send_req(DIV_FN_SIGNED, 100, -7);
    repeat (10) send_req(DIV_FN_SIGNED, $urandom, $urandom);
    end_test();
    #2;

    start_test("corner");
    send_req(DIV_FN_UNSIGNED, 1234, 0);
    send_req(DIV_FN_SIGNED, -5, 0);
    send_req(DIV_FN_SIGNED, 5, 0);
    send_req(DIV_FN_SIGNED, 32'h8000_0000, 32'hffff_ffff);
    end_test();

    // random output stalls with mixed functions
    start_test("random_stall");
    rdy_mode = RDY_RANDOM;
    #2;
    repeat (30) begin
      send_req(div_fn_e'($urandom_range(1)), $urandom, $urandom_range(5000, 0));
    end
    end_test();

    // three requests with the output blocked fill all three stages
    start_test("backpressure");
    rdy_mode = RDY_LOW;
    #2;
    send_req(DIV_FN_UNSIGNED, 1000, 3);
    send_req(DIV_FN_SIGNED, -1000, 7);
    send_req(DIV_FN_UNSIGNED, 77, 0);
    // core finishes the second division and still cannot hand it on
    repeat (40) begin
      @(posedge clk);
      assert (!req_rdy) else begin
        $display("FAIL %s expected req_rdy 0 actual %b", test_name, req_rdy);
        err_count++;
      end
    end
    rdy_mode = RDY_HIGH;
    end_test();

    total = err_count + int_div_unit_i.props_i.fail_cnt;
    $display("tests %0d, responses %0d, check errors %0d, assertion failures %0d",
             test_count, resp_count, err_count, int_div_unit_i.props_i.fail_cnt);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
div_pkg.sv
div_chan_if.sv
div_operand_stage.sv
div_iter_core.sv
div_result_stage.sv
int_div_unit.sv
tb_clock_gen.sv
int_div_unit_props.sv
int_div_unit_tb.sv
